// File: hw/cpuPkg.sv
package cpuPkg;

    localparam int WORD_W   = 16;
    localparam int NUM_REGS = 4;

    typedef logic [WORD_W-1:0] word_t;   // data word, address or instruction
    typedef logic [1:0]        regIdx_t;
    typedef logic [3:0]        opcode_t;
    typedef logic [5:0]        func_t;

    // instruction fields
    //   opcode [15:12], rs [11:10], rt [9:8], rd [7:6], func [5:0]
    //   immediate [7:0], jump target [11:0]

    localparam opcode_t OP_ADI   = 4'd4;
    localparam opcode_t OP_ORI   = 4'd5;
    localparam opcode_t OP_LHI   = 4'd6;
    localparam opcode_t OP_JMP   = 4'd9;
    localparam opcode_t OP_RTYPE = 4'd15;

    localparam func_t FN_ADD = 6'd0;
    localparam func_t FN_SUB = 6'd1;
    localparam func_t FN_AND = 6'd2;
    localparam func_t FN_ORR = 6'd3;
    localparam func_t FN_NOT = 6'd4;
    localparam func_t FN_TCP = 6'd5;
    localparam func_t FN_SHL = 6'd6;
    localparam func_t FN_SHR = 6'd7;
    localparam func_t FN_WWD = 6'd28;
    localparam func_t FN_HLT = 6'd29;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_NOT,
        ALU_TCP,
        ALU_SHL,
        ALU_SHR,
        ALU_PASSB    // LHI, immediate goes straight through
    } aluOp_t;

    typedef struct packed {
        logic    valid;
        aluOp_t  aluOp;
        word_t   opA;        // forwarded rs
        word_t   opB;        // forwarded rt or immediate
        regIdx_t dest;
        logic    regWrite;
        logic    wwd;
        logic    halt;
        word_t   wwdValue;
    } decodeExec_t;

    typedef struct packed {
        logic    valid;
        word_t   result;
        regIdx_t dest;
        logic    regWrite;
        logic    wwd;
        word_t   wwdValue;
        logic    halt;
    } execResult_t;

endpackage

// File: hw/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic            clk,
    input  logic            rstN,
    input  cpuPkg::regIdx_t rdIdxA,
    input  cpuPkg::regIdx_t rdIdxB,
    output cpuPkg::word_t   rdDataA,
    output cpuPkg::word_t   rdDataB,
    input  logic            wrEn,
    input  cpuPkg::regIdx_t wrIdx,
    input  cpuPkg::word_t   wrData
);
    import cpuPkg::*;

    word_t regs [NUM_REGS];

    // reads see the old value during a write; decode forwards around that
    assign rdDataA = regs[rdIdxA];
    assign rdDataB = regs[rdIdxB];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrIdx] <= wrData;
        end
    end

endmodule

// File: hw/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic                clk,
    input  logic                rstN,
    output cpuPkg::word_t       instrAddr,
    input  cpuPkg::word_t       instrData,
    output cpuPkg::regIdx_t     rdIdxA,
    output cpuPkg::regIdx_t     rdIdxB,
    input  cpuPkg::word_t       rdDataA,
    input  cpuPkg::word_t       rdDataB,
    input  cpuPkg::execResult_t execFwd,
    input  logic                wbEn,
    input  cpuPkg::regIdx_t     wbIdx,
    input  cpuPkg::word_t       wbData,
    output cpuPkg::decodeExec_t toExec
);
    import cpuPkg::*;

    word_t   pc;
    word_t   latchInstr;
    word_t   latchPc;       // address of the latched instruction
    logic    latchValid;
    logic    frozen;        // set once HLT is decoded

    opcode_t opcode;
    func_t   func;
    regIdx_t rs;
    regIdx_t rt;
    regIdx_t rd;

    aluOp_t  aluOp;
    logic    regWrite;
    logic    isWwd;
    logic    isHalt;
    logic    isJmp;
    logic    useImm;
    word_t   imm;
    regIdx_t dest;
    word_t   srcA;
    word_t   srcB;
    word_t   jmpTarget;
    logic    takeJmp;
    logic    takeHalt;

    // newest first: execute register, then the write in progress, then the file
    function automatic word_t forwardOperand(input regIdx_t idx, input word_t rfVal);
        if (execFwd.valid && execFwd.regWrite && execFwd.dest == idx) begin
            return execFwd.result;
        end else if (wbEn && wbIdx == idx) begin
            return wbData;
        end
        return rfVal;
    endfunction

    assign opcode    = latchInstr[15:12];
    assign rs        = latchInstr[11:10];
    assign rt        = latchInstr[9:8];
    assign rd        = latchInstr[7:6];
    assign func      = latchInstr[5:0];
    assign jmpTarget = {latchPc[15:12], latchInstr[11:0]};
    assign instrAddr = pc;
    assign rdIdxA    = rs;
    assign rdIdxB    = rt;
    assign takeJmp   = latchValid && isJmp;
    assign takeHalt  = latchValid && isHalt;

    always_comb begin
        aluOp    = ALU_ADD;
        regWrite = 1'b0;
        isWwd    = 1'b0;
        isHalt   = 1'b0;
        isJmp    = 1'b0;
        useImm   = 1'b0;
        dest     = rd;
        imm      = {{8{latchInstr[7]}}, latchInstr[7:0]};   // ADI sign extension
        case (opcode)
            OP_RTYPE: begin
                regWrite = 1'b1;
                case (func)
                    FN_ADD: aluOp = ALU_ADD;
                    FN_SUB: aluOp = ALU_SUB;
                    FN_AND: aluOp = ALU_AND;
                    FN_ORR: aluOp = ALU_OR;
                    FN_NOT: aluOp = ALU_NOT;
                    FN_TCP: aluOp = ALU_TCP;
                    FN_SHL: aluOp = ALU_SHL;
                    FN_SHR: aluOp = ALU_SHR;
                    FN_WWD: begin
                        regWrite = 1'b0;
                        isWwd    = 1'b1;
                    end
                    FN_HLT: begin
                        regWrite = 1'b0;
                        isHalt   = 1'b1;
                    end
                    default: regWrite = 1'b0;   // unknown func retires as a no-op
                endcase
            end
            OP_ADI: begin
                useImm   = 1'b1;
                dest     = rt;
                regWrite = 1'b1;
            end
            OP_ORI: begin
                aluOp    = ALU_OR;
                useImm   = 1'b1;
                imm      = {8'h00, latchInstr[7:0]};
                dest     = rt;
                regWrite = 1'b1;
            end
            OP_LHI: begin
                aluOp    = ALU_PASSB;
                useImm   = 1'b1;
                imm      = {latchInstr[7:0], 8'h00};
                dest     = rt;
                regWrite = 1'b1;
            end
            OP_JMP: isJmp = 1'b1;   // still counted, writes nothing
            default: ;
        endcase
    end

    always_comb begin
        srcA = forwardOperand(rs, rdDataA);
        srcB = forwardOperand(rt, rdDataB);
    end

    always_comb begin
        toExec.valid    = latchValid;
        toExec.aluOp    = aluOp;
        toExec.opA      = srcA;
        toExec.opB      = useImm ? imm : srcB;
        toExec.dest     = dest;
        toExec.regWrite = regWrite;
        toExec.wwd      = isWwd;
        toExec.halt     = isHalt;
        toExec.wwdValue = srcA;   // WWD prints rs
    end

    always_ff @(posedge clk) begin
        latchInstr <= instrData;
        latchPc    <= pc;
        if (!rstN) begin
            pc         <= '0;
            latchValid <= 1'b0;
            frozen     <= 1'b0;
        end else if (frozen || takeHalt) begin
            latchValid <= 1'b0;     // pc holds, nothing more enters
            frozen     <= 1'b1;
        end else if (takeJmp) begin
            pc         <= jmpTarget;
            latchValid <= 1'b0;     // squash the slot fetched behind the JMP
        end else begin
            pc         <= pc + word_t'(1);
            latchValid <= 1'b1;
        end
    end

endmodule

// File: hw/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic                clk,
    input  logic                rstN,
    input  cpuPkg::decodeExec_t fromDecode,
    output cpuPkg::execResult_t toResult
);
    import cpuPkg::*;

    word_t       a;
    word_t       b;
    word_t       aluOut;
    execResult_t nextResult;

    assign a = fromDecode.opA;
    assign b = fromDecode.opB;

    // all results wrap at 16 bits
    always_comb begin
        case (fromDecode.aluOp)
            ALU_ADD: begin
                aluOut = a + b;
            end
            ALU_SUB: begin
                aluOut = a - b;
            end
            ALU_AND: begin
                aluOut = a & b;
            end
            ALU_OR: begin
                aluOut = a | b;
            end
            ALU_NOT: begin
                aluOut = ~a;
            end
            ALU_TCP: begin
                aluOut = ~a + word_t'(1);     // two's complement negate
            end
            ALU_SHL: begin
                aluOut = {a[WORD_W-2:0], 1'b0};
            end
            ALU_SHR: begin
                aluOut = {a[WORD_W-1], a[WORD_W-1:1]};   // keeps the sign bit
            end
            ALU_PASSB: begin
                aluOut = b;
            end
            default: begin
                aluOut = '0;
            end
        endcase
    end

    always_comb begin
        nextResult.valid    = fromDecode.valid;
        nextResult.result   = aluOut;
        nextResult.dest     = fromDecode.dest;
        nextResult.regWrite = fromDecode.regWrite;
        nextResult.wwd      = fromDecode.wwd;
        nextResult.wwdValue = fromDecode.wwdValue;
        nextResult.halt     = fromDecode.halt;
    end

    // also the newest forwarding source for decode
    always_ff @(posedge clk) begin
        toResult <= nextResult;
        if (!rstN) begin
            toResult.valid <= 1'b0;
        end
    end

endmodule

// File: hw/resultStage.sv
`timescale 1ns/1ps

module resultStage (
    input  logic                clk,
    input  logic                rstN,
    input  cpuPkg::execResult_t fromExec,
    output logic                wbEn,
    output cpuPkg::regIdx_t     wbIdx,
    output cpuPkg::word_t       wbData,
    output cpuPkg::word_t       outputPort,
    output logic                outputValid,
    output cpuPkg::word_t       numInst,
    output logic                halted
);
    import cpuPkg::*;

    execResult_t entry;

    always_ff @(posedge clk) begin
        entry <= fromExec;
        if (!rstN) begin
            entry.valid <= 1'b0;
        end
    end

    // register file write happens at the edge after the entry lands here
    assign wbEn   = entry.valid && entry.regWrite;
    assign wbIdx  = entry.dest;
    assign wbData = entry.result;

    assign outputPort  = entry.wwdValue;
    assign outputValid = entry.valid && entry.wwd;   // one cycle per WWD

    // count and halt update as the entry is captured
    always_ff @(posedge clk) begin
        if (!rstN) begin
            numInst <= '0;
            halted  <= 1'b0;
        end else begin
            if (fromExec.valid) begin
                numInst <= numInst + word_t'(1);   // bubbles are not counted
            end
            if (fromExec.valid && fromExec.halt) begin
                halted <= 1'b1;     // sticky until reset
            end
        end
    end

endmodule

// File: hw/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
    input  logic          clk,
    input  logic          rstN,
    input  cpuPkg::word_t instrData,
    output cpuPkg::word_t instrAddr,
    output cpuPkg::word_t outputPort,
    output logic          outputValid,
    output cpuPkg::word_t numInst,
    output logic          halted
);
    import cpuPkg::*;

    regIdx_t     rdIdxA;
    regIdx_t     rdIdxB;
    word_t       rdDataA;
    word_t       rdDataB;
    logic        wbEn;
    regIdx_t     wbIdx;
    word_t       wbData;
    decodeExec_t decToExec;
    execResult_t execToResult;   // also fed back for forwarding

    decodeStage decodeStage_inst (
        .clk       (clk),
        .rstN      (rstN),
        .instrAddr (instrAddr),
        .instrData (instrData),
        .rdIdxA    (rdIdxA),
        .rdIdxB    (rdIdxB),
        .rdDataA   (rdDataA),
        .rdDataB   (rdDataB),
        .execFwd   (execToResult),
        .wbEn      (wbEn),
        .wbIdx     (wbIdx),
        .wbData    (wbData),
        .toExec    (decToExec)
    );

    registerFile registerFile_inst (
        .clk     (clk),
        .rstN    (rstN),
        .rdIdxA  (rdIdxA),
        .rdIdxB  (rdIdxB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (wbEn),
        .wrIdx   (wbIdx),
        .wrData  (wbData)
    );

    executeStage executeStage_inst (
        .clk        (clk),
        .rstN       (rstN),
        .fromDecode (decToExec),
        .toResult   (execToResult)
    );

    resultStage resultStage_inst (
        .clk         (clk),
        .rstN        (rstN),
        .fromExec    (execToResult),
        .wbEn        (wbEn),
        .wbIdx       (wbIdx),
        .wbData      (wbData),
        .outputPort  (outputPort),
        .outputValid (outputValid),
        .numInst     (numInst),
        .halted      (halted)
    );

endmodule

// File: sim/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk
);

    // 100 ns period, first rising edge at 50 ns
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

endmodule

// File: sim/cpuChecker.sv
`timescale 1ns/1ps

module cpuChecker (
    input  logic                clk,
    input  logic                rstN,
    input  cpuPkg::word_t       outputPort,
    input  logic                outputValid,
    input  cpuPkg::word_t       numInst,
    input  logic                halted,
    input  logic [8*12-1:0]     testName,
    input  cpuPkg::word_t [3:0] expVals,
    input  int                  expCount,
    input  cpuPkg::word_t       expNumInst,
    input  logic                finishTest,
    output int                  passCount,
    output int                  failCount
);
    import cpuPkg::*;

    word_t seen [8];            // WWD values in arrival order
    int    seenCount    = 0;
    int    sinceRelease = 0;
    int    passes       = 0;
    int    fails        = 0;
    logic  compared     = 1'b0; // halt already seen this test
    logic  testBad      = 1'b0;

    assign passCount = passes;
    assign failCount = fails;

    task automatic compareOutputs();
        for (int i = 0; i < expCount && i < seenCount; i++) begin
            if (seen[i] !== expVals[i]) begin
                $display("ERR @%0t: %0s output %0d is %h, expected %h",
                         $time, testName, i, seen[i], expVals[i]);
                testBad = 1'b1;
            end
        end
        if (seenCount < expCount) begin
            $display("test %0s is missing outputs, %0d expected but only %0d appeared",
                     testName, expCount, seenCount);
            testBad = 1'b1;
        end else if (seenCount > expCount) begin
            $display("test %0s produced %0d extra outputs beyond the %0d expected",
                     testName, seenCount - expCount, expCount);
            testBad = 1'b1;
        end
        if (numInst !== expNumInst) begin
            $display("ERR @%0t: %0s numInst is %0d, expected %0d",
                     $time, testName, numInst, expNumInst);
            testBad = 1'b1;
        end
    endtask

    // sampled on the rising edge, so every value is the settled one from the last cycle
    always @(posedge clk) begin
        if (!rstN) begin
            seenCount    = 0;
            sinceRelease = 0;
            compared     = 1'b0;
            testBad      = 1'b0;
        end else if (finishTest) begin
            if (testBad) begin
                fails++;
                $display("test %0s failed", testName);
            end else begin
                passes++;
                $display("test %0s passed", testName);
            end
        end else begin
            if (sinceRelease < 3) begin     // nothing can retire this early
                if (outputValid || halted || numInst !== '0) begin
                    $display("ERR @%0t: %0s not idle after reset (valid %b halted %b count %0d)",
                             $time, testName, outputValid, halted, numInst);
                    testBad = 1'b1;
                end
                sinceRelease++;
            end
            if (outputValid && compared) begin
                $display("test %0s wrote %h to the output after the halt", testName, outputPort);
                testBad = 1'b1;
            end else if (outputValid) begin
                if (seenCount < 8) begin
                    seen[seenCount] = outputPort;
                end
                seenCount++;
            end
            if (halted && !compared) begin
                compareOutputs();
                compared = 1'b1;
            end else if (!halted && compared) begin
                $display("test %0s saw halted drop before reset", testName);
                testBad = 1'b1;
            end
        end
    end

endmodule

// File: sim/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;
    import cpuPkg::*;

    localparam int NUM_TESTS = 8;
    localparam int MEM_WORDS = 16;

    typedef struct packed {
        logic [8*12-1:0] name;
        word_t [7:0]     prog;          // words past the program stay HLT
        int              progLen;       // program words up to and including the HLT
        word_t [3:0]     expVals;
        int              expCount;
        word_t           expNumInst;
    } testRow_t;

    logic     clk;
    logic     rstN       = 1'b0;
    word_t    instrData  = '0;
    word_t    instrAddr;
    word_t    outputPort;
    logic     outputValid;
    word_t    numInst;
    logic     halted;
    logic     finishTest = 1'b0;
    int       passCount;
    int       failCount;
    logic     timedOut;
    testRow_t cur        = '0;
    testRow_t tests [NUM_TESTS];
    word_t    mem [MEM_WORDS];

    tbClock clockGen (.clk(clk));

    cpuTop cpuTop_inst (
        .clk         (clk),
        .rstN        (rstN),
        .instrData   (instrData),
        .instrAddr   (instrAddr),
        .outputPort  (outputPort),
        .outputValid (outputValid),
        .numInst     (numInst),
        .halted      (halted)
    );

    cpuChecker cpuChecker_inst (
        .clk         (clk),
        .rstN        (rstN),
        .outputPort  (outputPort),
        .outputValid (outputValid),
        .numInst     (numInst),
        .halted      (halted),
        .testName    (cur.name),
        .expVals     (cur.expVals),
        .expCount    (cur.expCount),
        .expNumInst  (cur.expNumInst),
        .finishTest  (finishTest),
        .passCount   (passCount),
        .failCount   (failCount)
    );

    // the core latches instrData at the next rising edge
    always @(negedge clk) begin
        instrData = mem[instrAddr[3:0]];
    end

    function automatic word_t encodeR(input func_t fn, input regIdx_t rs, input regIdx_t rt,
                                      input regIdx_t rd);
        return {OP_RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic word_t encodeI(input opcode_t op, input regIdx_t rs, input regIdx_t rt,
                                      input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t encodeWwd(input regIdx_t rs);
        return encodeR(FN_WWD, rs, 2'd0, 2'd0);
    endfunction

    task automatic setRow(input int t, input logic [8*12-1:0] name, input int len,
                          input int cnt, input word_t e0, input word_t e1, input word_t n);
        tests[t].name       = name;
        tests[t].progLen    = len;
        tests[t].expCount   = cnt;
        tests[t].expVals[0] = e0;
        tests[t].expVals[1] = e1;
        tests[t].expNumInst = n;
    endtask

    // r1 = {hi, 0x34}, r2 = 0x00FF
    task automatic loadConstants(input int t, input logic [7:0] hi);
        tests[t].prog[0] = encodeI(OP_LHI, 2'd0, 2'd1, hi);
        tests[t].prog[1] = encodeI(OP_ORI, 2'd1, 2'd1, 8'h34);
        tests[t].prog[2] = encodeI(OP_ORI, 2'd0, 2'd2, 8'hFF);
    endtask

    // two ALU ops into r3, each printed right away
    task automatic aluPair(input int t, input func_t fa, input regIdx_t sa, input regIdx_t ta,
                           input func_t fb, input regIdx_t sb, input regIdx_t tB);
        tests[t].prog[3] = encodeR(fa, sa, ta, 2'd3);
        tests[t].prog[4] = encodeWwd(2'd3);
        tests[t].prog[5] = encodeR(fb, sb, tB, 2'd3);
        tests[t].prog[6] = encodeWwd(2'd3);
    endtask

    task automatic buildTable();
        word_t hlt;
        hlt = encodeR(FN_HLT, 2'd0, 2'd0, 2'd0);
        for (int t = 0; t < NUM_TESTS; t++) begin
            tests[t]      = '0;
            tests[t].prog = {8{hlt}};
        end
        setRow(0, "haltOnly", 1, 0, 16'h0000, 16'h0000, 16'd1);
        setRow(1, "immediates", 6, 2, 16'h1234, 16'hFFFF, 16'd6);
        tests[1].prog[0] = encodeI(OP_LHI, 2'd0, 2'd1, 8'h12);
        tests[1].prog[1] = encodeI(OP_ORI, 2'd1, 2'd1, 8'h34);
        tests[1].prog[2] = encodeWwd(2'd1);
        tests[1].prog[3] = encodeI(OP_ADI, 2'd0, 2'd2, 8'hFF);     // 0 + (-1)
        tests[1].prog[4] = encodeWwd(2'd2);
        // SUB of 0x00FF minus 0x1234 wraps below zero
        setRow(2, "addSub", 8, 2, 16'h1333, 16'hEECB, 16'd8);
        loadConstants(2, 8'h12);
        aluPair(2, FN_ADD, 2'd1, 2'd2, FN_SUB, 2'd2, 2'd1);
        setRow(3, "andOr", 8, 2, 16'h0034, 16'h12FF, 16'd8);
        loadConstants(3, 8'h12);
        aluPair(3, FN_AND, 2'd1, 2'd2, FN_ORR, 2'd1, 2'd2);
        setRow(4, "notTcp", 8, 2, 16'hEDCB, 16'hEDCC, 16'd8);
        loadConstants(4, 8'h12);
        aluPair(4, FN_NOT, 2'd1, 2'd0, FN_TCP, 2'd1, 2'd0);
        // 0x9234 is negative so SHR keeps the sign
        setRow(5, "shifts", 8, 2, 16'h2468, 16'hC91A, 16'd8);
        loadConstants(5, 8'h92);
        aluPair(5, FN_SHL, 2'd1, 2'd0, FN_SHR, 2'd1, 2'd0);
        // 5, 10, 15 with no gaps between producers and consumers
        setRow(6, "forwarding", 6, 2, 16'h000F, 16'h0005, 16'd6);
        tests[6].prog[0] = encodeI(OP_ADI, 2'd0, 2'd1, 8'd5);
        tests[6].prog[1] = encodeR(FN_ADD, 2'd1, 2'd1, 2'd2);
        tests[6].prog[2] = encodeR(FN_ADD, 2'd2, 2'd1, 2'd3);
        tests[6].prog[3] = encodeWwd(2'd3);
        tests[6].prog[4] = encodeWwd(2'd1);
        // jump from 2 to 5 skips both 0xDEAD prints
        setRow(7, "jump", 8, 1, 16'hDEAE, 16'h0000, 16'd6);
        tests[7].prog[0] = encodeI(OP_LHI, 2'd0, 2'd1, 8'hDE);
        tests[7].prog[1] = encodeI(OP_ORI, 2'd1, 2'd1, 8'hAD);
        tests[7].prog[2] = {OP_JMP, 12'd5};
        tests[7].prog[3] = encodeWwd(2'd1);
        tests[7].prog[4] = encodeWwd(2'd1);
        tests[7].prog[5] = encodeI(OP_ADI, 2'd1, 2'd2, 8'd1);
        tests[7].prog[6] = encodeWwd(2'd2);
    endtask

    task automatic runTest(input int t, output logic expired);
        int cycles;
        int limit;
        @(negedge clk);
        rstN = 1'b0;
        cur  = tests[t];
        for (int a = 0; a < MEM_WORDS; a++) begin
            if (a < 8) begin
                mem[a] = cur.prog[a];
            end else begin
                mem[a] = encodeR(FN_HLT, 2'd0, 2'd0, 2'd0);
            end
        end
        repeat (3) @(negedge clk);
        rstN    = 1'b1;
        limit   = 12 * cur.progLen + 10;
        cycles  = 0;
        expired = 1'b0;
        while (!halted && !expired) begin
            @(negedge clk);
            cycles++;
            if (cycles >= limit && !halted) begin
                expired = 1'b1;
            end
        end
        if (expired) begin
            $display("test %0s did not halt within %0d cycles, run stopped", cur.name, limit);
        end else begin
            repeat (3) @(negedge clk);      // window for stray outputs after the halt
            finishTest = 1'b1;
            @(negedge clk);
            finishTest = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(32'h6009e16a));
        timedOut = 1'b0;
        buildTable();
        for (int t = 0; t < NUM_TESTS && !timedOut; t++) begin
            runTest(t, timedOut);
        end
        @(negedge clk);
        $display("%0d tests passed, %0d failed", passCount, failCount + int'(timedOut));
        if (!timedOut && failCount == 0 && passCount == NUM_TESTS) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
hw/cpuPkg.sv
hw/registerFile.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/resultStage.sv
hw/cpuTop.sv
sim/tbClock.sv
sim/cpuChecker.sv
sim/cpuTb.sv

// File: run.sh
#!/bin/sh
set -e

verilator --binary --timescale 1ns/1ps --top-module cpuTb -f all.f -o cpuSim
out=$(./obj_dir/cpuSim)
echo "$out"
if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
